/* hdl/axi_pkg.sv */
// AXI4-Lite bus definitions
// Channel widths and response codes shared by the slave controllers
`default_nettype none

package axi_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////
  localparam int axi_addr_w = 32;  // Byte address
  localparam int axi_data_w = 32;  // One word per beat
  localparam int axi_strb_w = axi_data_w / 8;  // One strobe per byte lane

  //////////////////////////////
  // Response codes
  //////////////////////////////
  // Encodings as on BRESP / RRESP
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,  // Access refused by the slave
    resp_decerr = 2'b11   // No target at this address
  } axi_resp_e;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
// Memory subsystem address map
// Word memory size, region bases and config register offsets
`default_nettype none

package mem_pkg;

  // Word memory
  localparam int mem_depth  = 256;
  localparam int mem_addr_w = $clog2(mem_depth);  // Word index bits

  //////////////////////////////
  // Address map
  //////////////////////////////
  localparam logic [31:0] mem_base = 32'h0000_0000;
  localparam logic [31:0] mem_span = 32'h0000_0400;  // mem_depth words of 4 bytes
  localparam logic [31:0] cfg_base = 32'h0000_1000;

  // Config register offsets, anything else in the region is unmapped
  localparam logic [31:0] cfg_wp_limit_off = 32'h0;
  localparam logic [31:0] cfg_wr_count_off = 32'h4;

  // Register select on the config port
  localparam int cfg_addr_w = 1;
  localparam logic [cfg_addr_w-1:0] cfg_wp_sel  = cfg_addr_w'(cfg_wp_limit_off >> 2);
  localparam logic [cfg_addr_w-1:0] cfg_cnt_sel = cfg_addr_w'(cfg_wr_count_off >> 2);

endpackage

`default_nettype wire

/* hdl/mem_port_if.sv */
// Word access port between a bus controller and a storage block
// en is a one-cycle strobe, read data follows one cycle later
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if import axi_pkg::*, mem_pkg::*; ();

  logic                  en;     // Access strobe
  logic [mem_addr_w-1:0] addr;   // Word index
  logic [axi_data_w-1:0] wdata;
  logic [axi_strb_w-1:0] strb;   // Byte lane enables
  logic [axi_data_w-1:0] rdata;  // Valid the cycle after en

  // Controller side
  modport master (
    output en,
    output addr,
    output wdata,
    output strb,
    input  rdata
  );

  // Storage side
  modport target (
    input  en,
    input  addr,
    input  wdata,
    input  strb,
    output rdata
  );

endinterface

`default_nettype wire

/* hdl/axi_write_ctrl.sv */
// AXI4-Lite write channel controller
// Joins AW and W, decodes the target, checks write protection, answers on B
`timescale 1ns/10ps
`default_nettype none

module axi_write_ctrl import axi_pkg::*, mem_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  aresetn,
  input  wire logic [axi_addr_w-1:0] awaddr,
  input  wire logic                  awvalid,
  output      logic                  awready,
  input  wire logic [axi_data_w-1:0] wdata,
  input  wire logic [axi_strb_w-1:0] wstrb,
  input  wire logic                  wvalid,
  output      logic                  wready,
  output      axi_resp_e             bresp,
  output      logic                  bvalid,
  input  wire logic                  bready,
  input  wire logic [mem_addr_w-1:0] wp_limit,   // Words below are read-only
  output      logic                  wr_commit,  // Pulse per memory write
  mem_port_if.master                 mem_wr,
  mem_port_if.master                 cfg_wr
);

  typedef enum logic [1:0] {wr_idle, wr_decode, wr_resp} wr_state_e;

  wr_state_e             state;
  logic                  aw_held, w_held;  // Channel already taken
  logic [axi_addr_w-1:0] addr_q;
  logic [axi_data_w-1:0] data_q;
  logic [axi_strb_w-1:0] strb_q;
  logic [axi_addr_w-1:0] mem_off, cfg_off;
  logic [mem_addr_w-1:0] mem_idx;
  logic                  is_mem, is_wp, is_cnt;
  axi_resp_e             resp_d;

  wire aw_hs = awvalid && awready;
  wire w_hs  = wvalid && wready;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  assign mem_off = addr_q - mem_base;  // Wraps high below the base
  assign cfg_off = addr_q - cfg_base;
  assign is_mem  = (mem_off < mem_span);
  assign is_wp   = (cfg_off[axi_addr_w-1:2] == cfg_wp_limit_off[axi_addr_w-1:2]);
  assign is_cnt  = (cfg_off[axi_addr_w-1:2] == cfg_wr_count_off[axi_addr_w-1:2]);
  assign mem_idx = mem_off[mem_addr_w+1:2];

  always_comb begin
    if (is_mem) begin
      resp_d = (mem_idx < wp_limit) ? resp_slverr : resp_okay;  // Protected word
    end else if (is_wp) begin
      resp_d = resp_okay;
    end else if (is_cnt) begin
      resp_d = resp_slverr;  // Counter is read-only
    end else begin
      resp_d = resp_decerr;
    end
  end

  // Storage strobes, only in the decode cycle and only for okay writes
  assign mem_wr.en    = (state == wr_decode) && is_mem && (resp_d == resp_okay);
  assign mem_wr.addr  = mem_idx;
  assign mem_wr.wdata = data_q;
  assign mem_wr.strb  = strb_q;

  assign cfg_wr.en    = (state == wr_decode) && is_wp && (resp_d == resp_okay);
  assign cfg_wr.addr  = {{(mem_addr_w-cfg_addr_w){1'b0}}, cfg_wp_sel};
  assign cfg_wr.wdata = data_q;
  assign cfg_wr.strb  = strb_q;

  assign wr_commit = mem_wr.en;

  //////////////////////////////
  // Channel FSM
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= wr_idle;
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= resp_okay;
    end else begin
      case (state)
        wr_idle: begin
          if (aw_hs) begin
            aw_held <= 1'b1;
            awready <= 1'b0;  // Hold off AW until B done
          end else if (!aw_held) begin
            awready <= 1'b1;
          end
          if (w_hs) begin
            w_held <= 1'b1;
            wready <= 1'b0;
          end else if (!w_held) begin
            wready <= 1'b1;
          end
          // Both channels in, either order
          if ((aw_hs || aw_held) && (w_hs || w_held)) state <= wr_decode;
        end
        wr_decode: begin
          bresp  <= resp_d;
          bvalid <= 1'b1;
          state  <= wr_resp;
        end
        wr_resp: begin
          if (bready) begin  // bvalid is high here
            bvalid  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            awready <= 1'b1;  // Reopen both channels
            wready  <= 1'b1;
            state   <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // Captured request
  always_ff @(posedge aclk) begin
    if (aw_hs) addr_q <= awaddr;
    if (w_hs) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_read_ctrl.sv */
// AXI4-Lite read channel controller
// Decodes AR, fetches from memory or config registers, answers on R
`timescale 1ns/10ps
`default_nettype none

module axi_read_ctrl import axi_pkg::*, mem_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  aresetn,
  input  wire logic [axi_addr_w-1:0] araddr,
  input  wire logic                  arvalid,
  output      logic                  arready,
  output      logic [axi_data_w-1:0] rdata,
  output      axi_resp_e             rresp,
  output      logic                  rvalid,
  input  wire logic                  rready,
  mem_port_if.master                 mem_rd,
  mem_port_if.master                 cfg_rd
);

  typedef enum logic [1:0] {rd_idle, rd_fetch, rd_resp} rd_state_e;

  rd_state_e             state;
  logic [axi_addr_w-1:0] addr_q;
  logic [axi_addr_w-1:0] mem_off, cfg_off;
  logic                  is_mem, is_wp, is_cnt;
  logic                  src_cfg_q;  // Data comes from config block

  wire ar_hs = arvalid && arready;

  // Region decode on the captured address
  assign mem_off = addr_q - mem_base;
  assign cfg_off = addr_q - cfg_base;
  assign is_mem  = (mem_off < mem_span);
  assign is_wp   = (cfg_off[axi_addr_w-1:2] == cfg_wp_limit_off[axi_addr_w-1:2]);
  assign is_cnt  = (cfg_off[axi_addr_w-1:2] == cfg_wr_count_off[axi_addr_w-1:2]);

  // Read strobes in the fetch cycle
  assign mem_rd.en    = (state == rd_fetch) && is_mem;
  assign mem_rd.addr  = mem_off[mem_addr_w+1:2];
  assign mem_rd.wdata = '0;  // Read-only port
  assign mem_rd.strb  = '0;

  assign cfg_rd.en    = (state == rd_fetch) && (is_wp || is_cnt);
  assign cfg_rd.addr  = {{(mem_addr_w-cfg_addr_w){1'b0}}, (is_cnt ? cfg_cnt_sel : cfg_wp_sel)};
  assign cfg_rd.wdata = '0;
  assign cfg_rd.strb  = '0;

  // Targets hold rdata until their next strobe, so R stays stable
  always_comb begin
    if (rresp == resp_decerr) rdata = '0;
    else if (src_cfg_q)       rdata = cfg_rd.rdata;
    else                      rdata = mem_rd.rdata;
  end

  //////////////////////////////
  // Channel FSM
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= rd_idle;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rresp     <= resp_okay;
      src_cfg_q <= 1'b0;
    end else begin
      case (state)
        rd_idle: begin
          if (ar_hs) begin
            arready <= 1'b0;  // One read in flight
            state   <= rd_fetch;
          end else begin
            arready <= 1'b1;
          end
        end
        rd_fetch: begin
          rresp     <= (is_mem || is_wp || is_cnt) ? resp_okay : resp_decerr;
          src_cfg_q <= !is_mem;
          rvalid    <= 1'b1;
          state     <= rd_resp;
        end
        rd_resp: begin
          if (rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
            state   <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) addr_q <= araddr;
  end

endmodule

`default_nettype wire

/* hdl/mem_array.sv */
// Word memory, one strobed write port and one registered read port
`timescale 1ns/10ps
`default_nettype none

module mem_array import axi_pkg::*, mem_pkg::*; (
  input wire logic   aclk,
  mem_port_if.target wr,
  mem_port_if.target rd
);

  logic [axi_data_w-1:0] mem [mem_depth];  // No reset on contents

  //////////////////////////////
  // Write port
  //////////////////////////////
  // Each lane on its own strobe, all 16 patterns
  always_ff @(posedge aclk) begin
    if (wr.en) begin
      for (int lane = 0; lane < axi_strb_w; lane++) begin
        if (wr.strb[lane]) begin
          mem[wr.addr][lane*8 +: 8] <= wr.wdata[lane*8 +: 8];
        end
      end
    end
  end

  assign wr.rdata = '0;  // Write port returns nothing

  //////////////////////////////
  // Read port
  //////////////////////////////
  // Output holds between strobes
  always_ff @(posedge aclk) begin
    if (rd.en) begin
      rd.rdata <= mem[rd.addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_cfg_regs.sv */
// Config registers: write-protect limit and committed-write counter
`timescale 1ns/10ps
`default_nettype none

module mem_cfg_regs import axi_pkg::*, mem_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  aresetn,
  input  wire logic                  wr_commit,  // One memory write done
  output      logic [mem_addr_w-1:0] wp_limit,
  mem_port_if.target                 wr,
  mem_port_if.target                 rd
);

  logic [axi_data_w-1:0] wr_count;

  wire [cfg_addr_w-1:0] wr_sel = wr.addr[cfg_addr_w-1:0];
  wire [cfg_addr_w-1:0] rd_sel = rd.addr[cfg_addr_w-1:0];

  // Limit 0 leaves everything writable
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wp_limit <= '0;
    end else if (wr.en && (wr_sel == cfg_wp_sel)) begin
      wp_limit <= wr.wdata[mem_addr_w-1:0];  // Low bits only
    end
  end

  // Counts okay memory writes
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_count <= '0;
    end else if (wr_commit) begin
      wr_count <= wr_count + 1'b1;
    end
  end

  assign wr.rdata = '0;

  // Registered readback
  always_ff @(posedge aclk) begin
    if (rd.en) begin
      rd.rdata <= (rd_sel == cfg_cnt_sel) ? wr_count
                                          : {{(axi_data_w-mem_addr_w){1'b0}}, wp_limit};
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_mem_slave_top.sv */
// AXI4-Lite memory slave top
// Write and read controllers, word memory and config block
`timescale 1ns/10ps
`default_nettype none

module axi_mem_slave_top import axi_pkg::*, mem_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  aresetn,
  // Write address
  input  wire logic [axi_addr_w-1:0] awaddr,
  input  wire logic                  awvalid,
  output      logic                  awready,
  // Write data
  input  wire logic [axi_data_w-1:0] wdata,
  input  wire logic [axi_strb_w-1:0] wstrb,
  input  wire logic                  wvalid,
  output      logic                  wready,
  // Write response
  output      logic [1:0]            bresp,
  output      logic                  bvalid,
  input  wire logic                  bready,
  // Read address
  input  wire logic [axi_addr_w-1:0] araddr,
  input  wire logic                  arvalid,
  output      logic                  arready,
  // Read data
  output      logic [axi_data_w-1:0] rdata,
  output      logic [1:0]            rresp,
  output      logic                  rvalid,
  input  wire logic                  rready
);

  logic [mem_addr_w-1:0] wp_limit;
  logic                  wr_commit;

  // Storage ports
  mem_port_if mem_wr ();
  mem_port_if mem_rd ();
  mem_port_if cfg_wr ();
  mem_port_if cfg_rd ();

  axi_write_ctrl u_wr (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .wp_limit  (wp_limit),
    .wr_commit (wr_commit),
    .mem_wr    (mem_wr.master),
    .cfg_wr    (cfg_wr.master)
  );

  axi_read_ctrl u_rd (
    .aclk    (aclk),
    .aresetn (aresetn),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .mem_rd  (mem_rd.master),
    .cfg_rd  (cfg_rd.master)
  );

  mem_array u_mem (
    .aclk (aclk),
    .wr   (mem_wr.target),
    .rd   (mem_rd.target)
  );

  mem_cfg_regs u_cfg (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .wr_commit (wr_commit),
    .wp_limit  (wp_limit),
    .wr        (cfg_wr.target),
    .rd        (cfg_rd.target)
  );

endmodule

`default_nettype wire

/* testbench/tb_clkgen.sv */
// Testbench clock source
// Free-running aclk, 20 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic aclk
);

  localparam time half_period = 10ns;

  initial begin
    aclk = 1'b0;
    forever #(half_period) aclk = ~aclk;  // First rising edge at 10 ns
  end

endmodule

`default_nettype wire

/* testbench/tb_axi_mem.sv */
// AXI4-Lite memory slave testbench
// Table-driven writes and reads checked against a shadow memory and registers
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem import axi_pkg::*, mem_pkg::*; ();

  localparam int max_entries = 96;

  logic        aclk, aresetn;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  bit          t_rd    [max_entries];  // 1 for a read
  logic [31:0] t_addr  [max_entries];
  logic [31:0] t_data  [max_entries];
  logic [3:0]  t_strb  [max_entries];
  bit          t_stall [max_entries];  // Random wait on bready / rready
  axi_resp_e   t_resp  [max_entries];
  int          n_entries, n_wr, n_rd;

  // Shadow state
  logic [31:0]           shadow_mem [mem_depth];
  logic [mem_addr_w-1:0] shadow_wp;
  logic [31:0]           count_model;  // Okay memory writes so far

  int seed;
  int cycles, cycle_limit;
  int b_seen, r_seen;  // Handshakes seen on B and R

  tb_clkgen clkgen0 (.aclk(aclk));

  axi_mem_slave_top dut0 (
    .aclk(aclk), .aresetn(aresetn),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  task check_value(input string what, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task add_entry(input bit rd, input logic [31:0] addr, input logic [31:0] data,
                 input logic [3:0] strb, input bit stall, input axi_resp_e resp);
    t_rd[n_entries]    = rd;
    t_addr[n_entries]  = addr;
    t_data[n_entries]  = data;
    t_strb[n_entries]  = strb;
    t_stall[n_entries] = stall;
    t_resp[n_entries]  = resp;
    n_entries++;
    if (rd) n_rd++;
    else    n_wr++;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Only called for writes expected to be okay
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [31:0] off;
    off = addr - mem_base;
    if (off < mem_span) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) shadow_mem[off[mem_addr_w+1:2]][lane*8 +: 8] = data[lane*8 +: 8];
      end
      count_model++;
    end else begin
      shadow_wp = data[mem_addr_w-1:0];  // Only other okay write target
    end
  endtask

  function automatic logic [31:0] model_rdata(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - mem_base;
    if (off < mem_span) return shadow_mem[off[mem_addr_w+1:2]];
    off = addr - cfg_base;
    if (off[31:2] == cfg_wp_limit_off[31:2]) return {{(32-mem_addr_w){1'b0}}, shadow_wp};
    if (off[31:2] == cfg_wr_count_off[31:2]) return count_model;
    return 32'h0;  // Unmapped reads come back as zero
  endfunction

  //////////////////////////////
  // Bus tasks
  //////////////////////////////
  task automatic do_write(input int idx);
    int  aw_dly, w_dly, stall, cyc;
    bit  aw_done, w_done;
    @(posedge aclk);
    #1;
    aw_dly = 0;
    w_dly  = 0;
    stall  = 0;
    if (t_stall[idx]) begin  // Skew AW against W and hold off bready
      aw_dly = {$random(seed)} % 3;
      w_dly  = {$random(seed)} % 3;
      stall  = {$random(seed)} % 4 + 1;
    end
    awaddr  = t_addr[idx];
    wdata   = t_data[idx];
    wstrb   = t_strb[idx];
    bready  = (stall == 0);
    aw_done = 1'b0;
    w_done  = 1'b0;
    cyc     = 0;
    while (!(aw_done && w_done)) begin
      awvalid = !aw_done && (cyc >= aw_dly);
      wvalid  = !w_done && (cyc >= w_dly);
      @(negedge aclk);
      if (awvalid && awready) aw_done = 1'b1;  // Transfer at next edge
      if (wvalid && wready)   w_done  = 1'b1;
      @(posedge aclk);
      #1;
      cyc++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (stall) begin
      @(posedge aclk);
      #1;
    end
    bready = 1'b1;
    do @(negedge aclk); while (!bvalid);
    check_value("bresp", {30'b0, bresp}, {30'b0, t_resp[idx]});
    @(posedge aclk);
    #1;
    bready = 1'b0;
    @(negedge aclk);
    check_value("bvalid after B", {31'b0, bvalid}, 32'h0);  // Single response
    if (t_resp[idx] == resp_okay) model_write(t_addr[idx], t_data[idx], t_strb[idx]);
  endtask

  task automatic do_read(input int idx);
    int          stall;
    logic [31:0] exp_data;
    @(posedge aclk);
    #1;
    stall    = t_stall[idx] ? {$random(seed)} % 4 + 1 : 0;
    exp_data = (t_resp[idx] == resp_okay) ? model_rdata(t_addr[idx]) : 32'h0;
    araddr   = t_addr[idx];
    arvalid  = 1'b1;
    rready   = (stall == 0);
    do @(negedge aclk); while (!arready);
    @(posedge aclk);
    #1;
    arvalid = 1'b0;
    repeat (stall) begin
      @(posedge aclk);
      #1;
    end
    rready = 1'b1;
    do @(negedge aclk); while (!rvalid);
    check_value("rresp", {30'b0, rresp}, {30'b0, t_resp[idx]});
    check_value("rdata", rdata, exp_data);
    @(posedge aclk);
    #1;
    rready = 1'b0;
    @(negedge aclk);
    check_value("rvalid after R", {31'b0, rvalid}, 32'h0);
  endtask

  // Cycle watchdog and handshake counters
  always @(posedge aclk) begin
    cycles++;
    if (bvalid && bready) b_seen++;
    if (rvalid && rready) r_seen++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: no completion within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] rnd;
    seed    = 68275;
    aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    shadow_wp   = '0;
    count_model = '0;
    n_entries = 0;
    n_wr = 0;
    n_rd = 0;
    cycles = 0;
    cycle_limit = 0;
    b_seen = 0;
    r_seen = 0;

    add_entry(0, 32'h10, 32'hdead_beef, 4'hf, 0, resp_okay);  // Full word
    add_entry(1, 32'h10, 32'h0, 4'h0, 0, resp_okay);
    add_entry(0, 32'h40, 32'h0, 4'hf, 0, resp_okay);
    for (int p = 0; p < 16; p++) begin  // Every strobe pattern
      add_entry(0, 32'h40, 32'h1122_3344 ^ (32'(p) * 32'h0101_0101), 4'(p), 0, resp_okay);
      add_entry(1, 32'h40, 32'h0, 4'h0, 0, resp_okay);
    end
    add_entry(1, cfg_base + cfg_wr_count_off, 32'h0, 4'h0, 0, resp_okay);
    add_entry(0, cfg_base + cfg_wr_count_off, 32'h55, 4'hf, 0, resp_slverr);
    // Write protect below word 32
    add_entry(0, 32'h7c, 32'h7c7c_7c7c, 4'hf, 0, resp_okay);
    add_entry(0, cfg_base + cfg_wp_limit_off, 32'h20, 4'hf, 0, resp_okay);
    add_entry(1, cfg_base + cfg_wp_limit_off, 32'h0, 4'h0, 0, resp_okay);
    add_entry(0, 32'h7c, 32'hbad0_bad0, 4'hf, 0, resp_slverr);
    add_entry(0, 32'h0, 32'hbad1_bad1, 4'hf, 0, resp_slverr);
    add_entry(1, 32'h7c, 32'h0, 4'h0, 0, resp_okay);
    add_entry(0, 32'h80, 32'h8080_8080, 4'hf, 0, resp_okay);  // At the limit
    add_entry(1, 32'h80, 32'h0, 4'h0, 0, resp_okay);
    add_entry(0, cfg_base + cfg_wp_limit_off, 32'h0, 4'hf, 0, resp_okay);
    // Outside the map
    add_entry(0, 32'h400, 32'h1234_5678, 4'hf, 0, resp_decerr);
    add_entry(1, 32'h400, 32'h0, 4'h0, 0, resp_decerr);
    add_entry(0, cfg_base + 32'h8, 32'h1, 4'hf, 0, resp_decerr);
    add_entry(1, cfg_base + 32'hc, 32'h0, 4'h0, 0, resp_decerr);
    add_entry(1, 32'h2000, 32'h0, 4'h0, 0, resp_decerr);
    add_entry(1, 32'hffff_fffc, 32'h0, 4'h0, 0, resp_decerr);
    for (int i = 0; i < 12; i++) begin  // Back-pressure on B and R
      rnd = $random(seed);
      add_entry(0, 32'h100 + 32'(i) * 4, rnd, 4'hf, 1, resp_okay);
      add_entry(1, 32'h100 + 32'(i) * 4, 32'h0, 4'h0, 1, resp_okay);
    end
    add_entry(1, cfg_base + cfg_wr_count_off, 32'h0, 4'h0, 1, resp_okay);
    cycle_limit = n_entries * 40;

    repeat (2) @(posedge aclk);
    @(negedge aclk);
    check_value("awready in reset", {31'b0, awready}, 32'h0);
    check_value("wready in reset", {31'b0, wready}, 32'h0);
    check_value("arready in reset", {31'b0, arready}, 32'h0);
    @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    check_value("bvalid after reset", {31'b0, bvalid}, 32'h0);
    check_value("rvalid after reset", {31'b0, rvalid}, 32'h0);

    for (int i = 0; i < n_entries; i++) begin
      if (t_rd[i]) do_read(i);
      else         do_write(i);
    end
    check_value("B responses", b_seen, n_wr);
    check_value("R responses", r_seen, n_rd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/axi_pkg.sv
hdl/mem_pkg.sv
hdl/mem_port_if.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/mem_array.sv
hdl/mem_cfg_regs.sv
hdl/axi_mem_slave_top.sv
testbench/tb_clkgen.sv
testbench/tb_axi_mem.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI4-Lite memory slave testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_axi_mem -f tb.f -o tb_axi_mem_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_axi_mem_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
